//--- design/draw_params.svh
`ifndef DRAW_PARAMS_SVH
`define DRAW_PARAMS_SVH

// frame geometry.
`define HOR_PIXELS      64
`define VER_PIXELS      48

// one field wide enough for either axis.
`define COORD_BITS      6

`define PIXEL_ADDR_BITS 12  // covers HOR_PIXELS * VER_PIXELS.

`define COLOR_BITS      4
`define RESET_COLOR     15  // white on a 4-bit palette.

// host side command buffering.
`define CMD_QUEUE_DEPTH 8

`endif

//--- design/draw_pkg.sv
`default_nettype none
`include "draw_params.svh"

package draw_pkg;

    localparam int COORD_W = `COORD_BITS;
    localparam int COLOR_W = `COLOR_BITS;

    // opcode 3 is unassigned and decodes like a nop.
    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_LINE  = 2'd1,
        OP_COLOR = 2'd2
    } draw_op_e;

    // one command word, read as a line or as a color change.
    typedef union packed {
        struct packed {
            draw_op_e                op;
            logic [29-4*COORD_W:0]   pad;
            logic [COORD_W-1:0]      x1;
            logic [COORD_W-1:0]      y1;
            logic [COORD_W-1:0]      x2;
            logic [COORD_W-1:0]      y2;
        } line;
        struct packed {
            draw_op_e                op;
            logic [29-COLOR_W:0]     pad;
            logic [COLOR_W-1:0]      color;
        } color;
    } draw_cmd_u;

endpackage

`default_nettype wire

//--- design/line_job_if.sv
`timescale 1ns/10ps
`default_nettype none

interface line_job_if import draw_pkg::*; ();

    logic               start;  // one cycle, only while ready.
    logic               ready;

    // endpoints and color stay put until ready returns.
    logic [COORD_W-1:0] x1;
    logic [COORD_W-1:0] y1;
    logic [COORD_W-1:0] x2;
    logic [COORD_W-1:0] y2;
    logic [COLOR_W-1:0] color;

    modport sequencer (
        output start, x1, y1, x2, y2, color,
        input  ready
    );

    modport rasterizer (
        input  start, x1, y1, x2, y2, color,
        output ready
    );

endinterface

`default_nettype wire

//--- design/cmd_queue.sv
`timescale 1ns/10ps
`default_nettype none
`include "draw_params.svh"

module cmd_queue (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push,
    input  logic        pop,
    input  logic [31:0] push_word,
    output logic [31:0] head_word,
    output logic        empty,
    output logic        full
);

    localparam int DEPTH = `CMD_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [31:0]      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap by compare, depth need not be a power of two.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign do_push = push && !full;   // writes while full are lost.
    assign do_pop  = pop && !empty;

    assign head_word = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or neither.
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/cmd_sequencer.sv
`timescale 1ns/10ps
`default_nettype none
`include "draw_params.svh"

module cmd_sequencer import draw_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  draw_cmd_u     head_word,
    input  logic          empty,
    output logic          pop,
    output logic          active,
    line_job_if.sequencer job
);

    logic [COLOR_W-1:0] cur_color;
    logic               take_line;
    logic               take_color;

    // the rasterizer still shows ready during the start cycle, so hold off then.
    assign pop = !empty && job.ready && !job.start;

    assign take_line  = pop && (head_word.line.op == OP_LINE);
    assign take_color = pop && (head_word.color.op == OP_COLOR);

    // a popped line waiting for the rasterizer to pick it up.
    assign active = job.start;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            job.start <= 1'b0;
            cur_color <= COLOR_W'(`RESET_COLOR);
        end else begin
            job.start <= take_line;
            if (take_color) begin
                cur_color <= head_word.color.color;
            end
        end
    end

    // job payload, only touched when a line is accepted.
    always_ff @(posedge clk) begin
        if (take_line) begin
            job.x1    <= head_word.line.x1;
            job.y1    <= head_word.line.y1;
            job.x2    <= head_word.line.x2;
            job.y2    <= head_word.line.y2;
            job.color <= cur_color;  // color in force at pop time.
        end
    end

endmodule

`default_nettype wire

//--- design/line_rasterizer.sv
`timescale 1ns/10ps
`default_nettype none
`include "draw_params.svh"

module line_rasterizer import draw_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    line_job_if.rasterizer              job,
    output logic                        write_enable,
    output logic [`PIXEL_ADDR_BITS-1:0] write_addr,
    output logic [`COLOR_BITS-1:0]      write_data
);

    localparam int ADDR_W = `PIXEL_ADDR_BITS;
    localparam int ERR_W  = COORD_W + 1;

    logic               drawing;
    logic [COORD_W-1:0] dx;
    logic [COORD_W-1:0] dy;
    logic               primary_is_x;
    logic [COORD_W-1:0] p_start;
    logic [COORD_W-1:0] p_end;
    logic [COORD_W-1:0] s_start;
    logic [COORD_W-1:0] s_end;
    logic [COORD_W-1:0] p;
    logic [COORD_W-1:0] s;
    logic [ERR_W-1:0]   error;
    logic [ERR_W-1:0]   err_step;
    logic [ERR_W-1:0]   err_limit;
    logic [ERR_W:0]     err_sum;
    logic               s_advance;
    logic [COORD_W-1:0] col;
    logic [COORD_W-1:0] row;

    function automatic logic [COORD_W-1:0] abs_diff(
        input logic [COORD_W-1:0] a,
        input logic [COORD_W-1:0] b
    );
        return (a > b) ? a - b : b - a;
    endfunction

    // one unit toward target, none once there.
    function automatic logic [COORD_W-1:0] step_toward(
        input logic [COORD_W-1:0] value,
        input logic [COORD_W-1:0] target
    );
        if (value < target) begin
            return value + 1'b1;
        end else if (value > target) begin
            return value - 1'b1;
        end
        return value;
    endfunction

    assign dx = abs_diff(job.x1, job.x2);
    assign dy = abs_diff(job.y1, job.y2);

    assign primary_is_x = dx > dy;  // a tie goes to y.

    assign p_start = primary_is_x ? job.x1 : job.y1;
    assign p_end   = primary_is_x ? job.x2 : job.y2;
    assign s_start = primary_is_x ? job.y1 : job.x1;
    assign s_end   = primary_is_x ? job.y2 : job.x2;

    // error runs in units of (secondary delta + 1) against (primary delta + 1).
    assign err_step  = {1'b0, primary_is_x ? dy : dx} + 1'b1;
    assign err_limit = {1'b0, primary_is_x ? dx : dy} + 1'b1;
    assign err_sum   = {1'b0, error} + {1'b0, err_step};
    assign s_advance = err_sum >= {1'b0, err_limit};

    assign job.ready    = !drawing;
    assign write_enable = drawing;

    assign col        = primary_is_x ? p : s;
    assign row        = primary_is_x ? s : p;
    assign write_addr = ADDR_W'(row) * ADDR_W'(`HOR_PIXELS) + ADDR_W'(col);
    assign write_data = job.color;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drawing <= 1'b0;
            error   <= '0;
            p       <= '0;
            s       <= '0;
        end else if (!drawing) begin
            if (job.start) begin
                drawing <= 1'b1;
                error   <= '0;
                p       <= p_start;
                s       <= s_start;
            end
        end else begin
            if (p == p_end) begin
                drawing <= 1'b0;  // last pixel goes out this cycle.
            end
            p <= step_toward(p, p_end);
            if (s_advance) begin
                s     <= step_toward(s, s_end);
                error <= ERR_W'(err_sum - {1'b0, err_limit});
            end else begin
                error <= ERR_W'(err_sum);
            end
        end
    end

endmodule

`default_nettype wire

//--- design/frame_buffer.sv
`timescale 1ns/10ps
`default_nettype none
`include "draw_params.svh"

module frame_buffer (
    input  logic                        clk,
    input  logic                        write_enable,
    input  logic [`PIXEL_ADDR_BITS-1:0] write_addr,
    input  logic [`COLOR_BITS-1:0]      write_data,
    input  logic [`PIXEL_ADDR_BITS-1:0] rd_addr,
    output logic [`COLOR_BITS-1:0]      rd_data
);

    localparam int PIXEL_COUNT = `HOR_PIXELS * `VER_PIXELS;

    // row major, row * HOR_PIXELS + column.
    logic [`COLOR_BITS-1:0] mem [PIXEL_COUNT];

    // blank frame at time zero.
    initial begin
        for (int i = 0; i < PIXEL_COUNT; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
    end

    // one cycle read latency.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- design/draw_engine_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "draw_params.svh"

module draw_engine_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cmd_write,
    input  logic [31:0]                 cmd_word,
    input  logic [`PIXEL_ADDR_BITS-1:0] rd_addr,
    output logic                        cmd_full,
    output logic                        busy,
    output logic [`COLOR_BITS-1:0]      rd_data
);

    logic                        queue_empty;
    logic                        queue_pop;
    logic [31:0]                 head_word;
    logic                        seq_active;
    logic                        write_enable;
    logic [`PIXEL_ADDR_BITS-1:0] write_addr;
    logic [`COLOR_BITS-1:0]      write_data;

    line_job_if job ();

    cmd_queue u_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (cmd_write),
        .pop       (queue_pop),
        .push_word (cmd_word),
        .head_word (head_word),
        .empty     (queue_empty),
        .full      (cmd_full)
    );

    cmd_sequencer u_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .head_word (head_word),
        .empty     (queue_empty),
        .pop       (queue_pop),
        .active    (seq_active),
        .job       (job.sequencer)
    );

    line_rasterizer u_rasterizer (
        .clk          (clk),
        .rst_n        (rst_n),
        .job          (job.rasterizer),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .write_data   (write_data)
    );

    frame_buffer u_frame (
        .clk          (clk),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

    // anything queued, handed over, or still being drawn.
    assign busy = !queue_empty || seq_active || !job.ready;

endmodule

`default_nettype wire

//--- tb/draw_engine_assertions.sv
`timescale 1ns/10ps
`default_nettype none
`include "draw_params.svh"

module draw_engine_assertions (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        cmd_write,
    input logic                        cmd_full,
    input logic                        start,
    input logic                        ready,
    input logic                        write_enable,
    input logic [`PIXEL_ADDR_BITS-1:0] write_addr
);

    localparam int PIXEL_COUNT = `HOR_PIXELS * `VER_PIXELS;

    // host must hold off while the queue is full.
    no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_write |-> !cmd_full)
        else $error("command word written while the queue was full");

    // a run of pixel writes opens only on a start pulse given while ready.
    draw_follows_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(write_enable) |-> $past(start && ready))
        else $error("pixel writes began without a start pulse while ready");

    addr_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        write_enable |-> (write_addr < PIXEL_COUNT))
        else $error("pixel write address outside the frame");

endmodule

bind draw_engine_top draw_engine_assertions u_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_write    (cmd_write),
    .cmd_full     (cmd_full),
    .start        (job.start),
    .ready        (job.ready),
    .write_enable (write_enable),
    .write_addr   (write_addr)
);

`default_nettype wire

//--- tb/draw_engine_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "draw_params.svh"

module draw_engine_tb import draw_pkg::*; ();

    localparam int HOR           = `HOR_PIXELS;
    localparam int VER           = `VER_PIXELS;
    localparam int PIXELS        = HOR * VER;
    localparam int NUM_CMDS      = 240;  // upper bound over all tests.
    localparam int NUM_READBACKS = 7;
    localparam int WATCHDOG_CYCLES = NUM_CMDS * (HOR + 8) + NUM_READBACKS * (PIXELS + 8) + 5;

    logic                        clk;
    logic                        rst_n;
    logic                        cmd_write;
    logic [31:0]                 cmd_word;
    logic [`PIXEL_ADDR_BITS-1:0] rd_addr;
    logic                        cmd_full;
    logic                        busy;
    logic [`COLOR_BITS-1:0]      rd_data;

    logic [COLOR_W-1:0] model_frame [PIXELS];
    logic [COLOR_W-1:0] model_color;
    int                 error_count = 0;
    int                 test_count = 0;
    int                 tests_failed = 0;

    draw_engine_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_write (cmd_write),
        .cmd_word  (cmd_word),
        .rd_addr   (rd_addr),
        .cmd_full  (cmd_full),
        .busy      (busy),
        .rd_data   (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the engine did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    task automatic compare_pixel(input int addr, input logic [COLOR_W-1:0] got,
                                 input logic [COLOR_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: pixel %0d read %0h, expected %0h", $time, addr, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %b, expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    // reference drawing, primary axis plus error accumulation.
    task automatic model_line(input int x1, input int y1, input int x2, input int y2);
        int  dx, dy, pd, sd, p, pe, s, se, err;
        bit  x_major;
        dx = (x2 > x1) ? x2 - x1 : x1 - x2;
        dy = (y2 > y1) ? y2 - y1 : y1 - y2;
        x_major = dx > dy;  // tie goes to y.
        pd = x_major ? dx : dy;
        sd = x_major ? dy : dx;
        p  = x_major ? x1 : y1;
        pe = x_major ? x2 : y2;
        s  = x_major ? y1 : x1;
        se = x_major ? y2 : x2;
        err = 0;
        for (int i = 0; i <= pd; i++) begin
            if (x_major) model_frame[s * HOR + p] = model_color;
            else model_frame[p * HOR + s] = model_color;
            err += sd + 1;
            if (err >= pd + 1) begin
                err -= pd + 1;
                s += (s < se) ? 1 : (s > se) ? -1 : 0;
            end
            p += (p < pe) ? 1 : (p > pe) ? -1 : 0;
        end
    endtask

    task automatic model_apply(input draw_cmd_u cmd);
        case (cmd.line.op)
            OP_LINE:  model_line(cmd.line.x1, cmd.line.y1, cmd.line.x2, cmd.line.y2);
            OP_COLOR: model_color = cmd.color.color;
            default:  ;  // nop and the spare opcode.
        endcase
    endtask

    function automatic draw_cmd_u line_cmd(input int x1, input int y1, input int x2, input int y2);
        draw_cmd_u cmd;
        cmd = '0;
        cmd.line.op = OP_LINE;
        cmd.line.x1 = COORD_W'(x1);
        cmd.line.y1 = COORD_W'(y1);
        cmd.line.x2 = COORD_W'(x2);
        cmd.line.y2 = COORD_W'(y2);
        return cmd;
    endfunction

    function automatic draw_cmd_u color_cmd(input int color);
        draw_cmd_u cmd;
        cmd = '0;
        cmd.color.op    = OP_COLOR;
        cmd.color.color = COLOR_W'(color);
        return cmd;
    endfunction

    function automatic draw_cmd_u random_cmd();
        int x1, y1, x2, y2;
        if ($urandom % 5 == 0) return color_cmd($urandom % 16);
        x1 = $urandom % HOR;
        y1 = $urandom % VER;
        x2 = $urandom % HOR;
        y2 = $urandom % VER;
        return line_cmd(x1, y1, x2, y2);
    endfunction

    // word goes out on a falling edge once the queue has room.
    task automatic send_cmd(input draw_cmd_u cmd);
        @(negedge clk);
        cmd_write = 1'b0;
        while (cmd_full) @(negedge clk);
        cmd_write = 1'b1;
        cmd_word  = cmd;
        model_apply(cmd);
    endtask

    task automatic wait_idle();
        @(negedge clk);
        cmd_write = 1'b0;
        while (busy) @(negedge clk);
    endtask

    // read address leads the data by one edge.
    task automatic check_frame();
        for (int a = 0; a <= PIXELS; a++) begin
            @(negedge clk);
            if (a > 0) compare_pixel(a - 1, rd_data, model_frame[a - 1]);
            if (a < PIXELS) rd_addr = a[`PIXEL_ADDR_BITS-1:0];
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    initial begin
        int mark;
        draw_cmd_u cmd;
        void'($urandom(2));
        rst_n     = 1'b0;
        cmd_write = 1'b0;
        cmd_word  = '0;
        rd_addr   = '0;
        model_color = COLOR_W'(`RESET_COLOR);
        for (int i = 0; i < PIXELS; i++) model_frame[i] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        mark = error_count;
        compare_flag("busy", busy, 1'b0);
        compare_flag("cmd_full", cmd_full, 1'b0);
        check_frame();
        finish_test("reset state", mark);

        mark = error_count;
        send_cmd(line_cmd(10, 10, 10, 10));
        send_cmd(line_cmd(2, 5, 40, 5));
        send_cmd(line_cmd(50, 7, 20, 7));
        send_cmd(line_cmd(3, 1, 3, 40));
        send_cmd(line_cmd(60, 45, 60, 2));
        send_cmd(line_cmd(5, 10, 25, 30));
        send_cmd(line_cmd(40, 30, 20, 10));
        wait_idle();
        check_frame();
        finish_test("simple lines", mark);

        mark = error_count;
        send_cmd(color_cmd(3));
        wait_idle();
        check_frame();  // color alone draws nothing.
        send_cmd(line_cmd(0, 47, 63, 0));
        wait_idle();
        check_frame();
        finish_test("color change", mark);

        mark = error_count;
        for (int i = 0; i < 200; i++) begin
            cmd = random_cmd();
            send_cmd(cmd);
        end
        wait_idle();
        check_frame();
        finish_test("random commands", mark);

        mark = error_count;
        send_cmd(line_cmd(0, 0, 63, 47));  // keeps the rasterizer busy.
        send_cmd(color_cmd(5));
        for (int i = 0; i < 7; i++) begin
            cmd = random_cmd();
            send_cmd(cmd);
        end
        @(negedge clk);
        cmd_write = 1'b0;
        compare_flag("cmd_full", cmd_full, 1'b1);
        send_cmd(line_cmd(0, 46, 63, 46));
        wait_idle();
        check_frame();
        finish_test("queue back-pressure", mark);

        mark = error_count;
        cmd = '0;
        cmd.line.x2 = 6'd9;
        send_cmd(cmd);
        send_cmd('0);
        cmd = 32'hC00A_BCDE;  // spare opcode.
        send_cmd(cmd);
        @(negedge clk);
        cmd_write = 1'b0;
        compare_flag("busy", busy, 1'b1);  // last word not yet popped.
        wait_idle();
        compare_flag("cmd_full", cmd_full, 1'b0);
        check_frame();
        finish_test("nop words", mark);

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 test_count, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/draw_pkg.sv
design/line_job_if.sv
design/cmd_queue.sv
design/cmd_sequencer.sv
design/line_rasterizer.sv
design/frame_buffer.sv
design/draw_engine_top.sv
tb/draw_engine_assertions.sv
tb/draw_engine_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module draw_engine_tb -o draw_engine_sim

out=$(./obj_dir/draw_engine_sim)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
    echo "simulation passed"
else
    echo "simulation did not pass"
    exit 1
fi
